// ==== hdl/uart_params.svh ====
// Frame geometry and parity default for the UART link, included by the RTL and the testbench
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// Data bits per frame, sent LSB first
`define UART_DATA_BITS 8

// Line bits per frame
// start + data + parity + stop
`define UART_FRAME_BITS 11

// Parity mode used when the top level is not overridden
// 0 selects even parity, 1 selects odd parity
`define UART_PARITY_ODD_DEFAULT 1'b0

// Level of an idle line, also the stop bit level
`define UART_IDLE_LEVEL 1'b1

// Level of the start bit
`define UART_START_LEVEL 1'b0

`endif

// ==== hdl/uart_pkg.sv ====
// Shared UART types for the transmitter, the receiver, the top level and the testbench
`include "uart_params.svh"

package uart_pkg;

    // One payload byte on the serial line
    typedef logic [`UART_DATA_BITS-1:0] uart_byte_t;

    // Position within a frame, wide enough for all 11 line bits
    typedef logic [3:0] bit_index_t;

    // Transmitter FSM
    typedef enum logic
    {
        TX_IDLE,                                // Line held at stop level
        TX_SEND                                 // Frame bits going out
    } tx_state_t;

    // Receiver FSM
    typedef enum logic [1:0]
    {
        RX_IDLE,                                // Waiting for a start bit
        RX_DATA,                                // Shifting in data bits
        RX_PARITY,                              // Sampling parity bit
        RX_STOP                                 // Sampling stop bit
    } rx_state_t;

    // Outcome of one received frame, 10 bits
    typedef struct packed
    {
        uart_byte_t data;                       // Recovered byte
        logic       parity_error;               // Parity bit broke the rule
        logic       frame_error;                // Stop bit seen as 0
    } uart_rx_result_t;

endpackage

// ==== hdl/uart_tx.sv ====
// UART transmitter, one line bit per baud_clk, pulse start_tx while tx_busy is low to send a byte
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_tx
    import uart_pkg::*;
#(
    parameter bit PARITY_ODD = `UART_PARITY_ODD_DEFAULT   // 0 even, 1 odd
)
(
    input  logic       baud_clk,
    input  logic       reset,
    input  uart_byte_t tx_data,                 // Byte to send, sampled on acceptance
    input  logic       start_tx,                // Send request, ignored while busy
    output logic       tx,                      // Serial line out
    output logic       tx_busy                  // High for the ten cycles after acceptance
);

    localparam bit_index_t LAST_BIT = bit_index_t'(`UART_FRAME_BITS - 1);

    tx_state_t                   state;         // Transmit FSM
    bit_index_t                  bit_index;     // Next frame bit to drive
    logic [`UART_FRAME_BITS-1:0] frame;         // Stop, parity, data, start
    logic                        parity_bit;    // Parity of the byte being captured
    logic                        accept;        // Request taken this edge

    // Parity follows the byte latched at the accepting edge, so later
    // changes on tx_data never reach the frame
    assign parity_bit = (^tx_data) ^ PARITY_ODD;

    assign accept  = start_tx && (state == TX_IDLE);
    assign tx_busy = (state == TX_SEND);        // Straight from a flop, no decode glitch

    // Frame capture, payload only
    always_ff @(posedge baud_clk)
    begin
        if (accept)
        begin
            frame <= {`UART_IDLE_LEVEL, parity_bit, tx_data, `UART_START_LEVEL};
        end
    end

    // Line driver and bit sequencing
    always_ff @(posedge baud_clk or posedge reset)
    begin
        if (reset)
        begin
            state     <= TX_IDLE;
            bit_index <= '0;
            tx        <= `UART_IDLE_LEVEL;      // Idle line is high
        end
        else
        begin
            case (state)
                TX_IDLE:
                begin
                    if (accept)
                    begin
                        tx        <= `UART_START_LEVEL;   // Start bit goes out now
                        bit_index <= bit_index_t'(1);     // Bit 0 of frame is start
                        state     <= TX_SEND;
                    end
                end
                TX_SEND:
                begin
                    tx <= frame[bit_index];               // Data, parity, then stop
                    if (bit_index == LAST_BIT)
                    begin
                        bit_index <= '0;
                        state     <= TX_IDLE;             // Busy drops with the stop bit
                    end
                    else
                    begin
                        bit_index <= bit_index + bit_index_t'(1);
                    end
                end
                default:
                begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== hdl/uart_rx.sv ====
// UART receiver, samples rx once per baud_clk and pulses rx_valid with the frame result
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_rx
    import uart_pkg::*;
#(
    parameter bit PARITY_ODD = `UART_PARITY_ODD_DEFAULT   // 0 even, 1 odd
)
(
    input  logic            baud_clk,
    input  logic            reset,
    input  logic            rx,                 // Serial line in, asynchronous
    output logic            rx_valid,           // One-cycle pulse per frame
    output uart_rx_result_t rx_result           // Held until the next frame ends
);

    localparam bit_index_t LAST_DATA = bit_index_t'(`UART_DATA_BITS - 1);

    rx_state_t  state;                          // Receive FSM
    bit_index_t bit_index;                      // Data bit being sampled
    logic       rx_meta;                        // Synchronizer first stage
    logic       rx_sync;                        // Synchronized line
    logic       parity_acc;                     // XOR of data and parity bits so far
    uart_byte_t shift_data;                     // Data bits, LSB arrives first

    // Two-flop synchronizer, presets to idle so reset does not look like a start bit
    always_ff @(posedge baud_clk or posedge reset)
    begin
        if (reset)
        begin
            rx_meta <= `UART_IDLE_LEVEL;
            rx_sync <= `UART_IDLE_LEVEL;
        end
        else
        begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // Data shifter, payload only
    always_ff @(posedge baud_clk)
    begin
        if (state == RX_DATA)
        begin
            shift_data <= {rx_sync, shift_data[`UART_DATA_BITS-1:1]};   // Shift toward LSB
        end
    end

    // Frame FSM and result register
    always_ff @(posedge baud_clk or posedge reset)
    begin
        if (reset)
        begin
            state      <= RX_IDLE;
            bit_index  <= '0;
            parity_acc <= 1'b0;
            rx_valid   <= 1'b0;
            rx_result  <= '0;
        end
        else
        begin
            rx_valid <= 1'b0;                   // Pulse lasts one cycle
            case (state)
                RX_IDLE:
                begin
                    if (rx_sync == `UART_START_LEVEL)
                    begin
                        bit_index  <= '0;
                        parity_acc <= 1'b0;
                        state      <= RX_DATA;
                    end
                end
                RX_DATA:
                begin
                    parity_acc <= parity_acc ^ rx_sync;
                    if (bit_index == LAST_DATA)
                    begin
                        state <= RX_PARITY;
                    end
                    else
                    begin
                        bit_index <= bit_index + bit_index_t'(1);
                    end
                end
                RX_PARITY:
                begin
                    // Folding the parity bit in leaves the mode value when the frame is clean
                    parity_acc <= parity_acc ^ rx_sync;
                    state      <= RX_STOP;
                end
                RX_STOP:
                begin
                    rx_valid               <= 1'b1;
                    rx_result.data         <= shift_data;
                    rx_result.parity_error <= parity_acc ^ PARITY_ODD;
                    rx_result.frame_error  <= (rx_sync != `UART_IDLE_LEVEL);   // Stop must be 1
                    state                  <= RX_IDLE;   // Next start bit caught next cycle
                end
                default:
                begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== hdl/uart_link.sv ====
// UART link top level with independent transmit and receive paths sharing baud_clk and parity mode
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_link
    import uart_pkg::*;
#(
    parameter bit PARITY_ODD = `UART_PARITY_ODD_DEFAULT   // Applied to both directions
)
(
    input  logic            baud_clk,           // One line bit per cycle
    input  logic            reset,              // Async, active high
    input  uart_byte_t      tx_data,            // Byte to send
    input  logic            start_tx,           // Send strobe
    output logic            tx,                 // Serial out
    output logic            tx_busy,            // Transmit in progress
    input  logic            rx,                 // Serial in
    output logic            rx_valid,           // Result strobe
    output uart_rx_result_t rx_result           // Received byte and error flags
);

    // Transmit path
    uart_tx
    #(
        .PARITY_ODD (PARITY_ODD)
    )
    u_tx
    (
        .baud_clk   (baud_clk),
        .reset      (reset),
        .tx_data    (tx_data),
        .start_tx   (start_tx),
        .tx         (tx),
        .tx_busy    (tx_busy)
    );

    // Receive path, no back-pressure toward the line
    uart_rx
    #(
        .PARITY_ODD (PARITY_ODD)
    )
    u_rx
    (
        .baud_clk   (baud_clk),
        .reset      (reset),
        .rx         (rx),
        .rx_valid   (rx_valid),
        .rx_result  (rx_result)
    );

endmodule

// ==== testbench/tb_clock_gen.sv ====
// Testbench clock and reset source, 8 ns baud_clk with reset held for the first two rising edges
`timescale 1ns/1ps

module tb_clock_gen
#(
    parameter int PERIOD_NS    = 8,             // One line bit per period
    parameter int RESET_CYCLES = 2              // Rising edges spent in reset
)
(
    output logic baud_clk,
    output logic reset
);

    initial
    begin
        baud_clk = 1'b0;
        forever #(PERIOD_NS / 2) baud_clk = ~baud_clk;
    end

    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge baud_clk);
        reset <= 1'b0;                          // Released on an edge, like the stimulus
    end

endmodule

// ==== testbench/uart_link_assertions.sv ====
// Concurrent protocol checks on the UART link ports, attached to every uart_link by bind
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_link_assertions
(
    input logic baud_clk,
    input logic reset,
    input logic tx,
    input logic tx_busy,
    input logic rx_valid
);

    localparam int BUSY_CYCLES = `UART_FRAME_BITS - 1;   // Start plus ten more edges

    int busy_run;                               // Consecutive busy cycles seen

    always_ff @(posedge baud_clk or posedge reset)
    begin
        if (reset)
        begin
            busy_run <= 0;
        end
        else if (tx_busy)
        begin
            busy_run <= busy_run + 1;
        end
        else
        begin
            busy_run <= 0;
        end
    end

    // Line rests at the stop level between frames
    idle_line_high: assert property (@(posedge baud_clk) disable iff (reset)
        (!tx_busy && !$past(tx_busy)) |-> tx)
        else $error("tx not at idle level while transmitter idle");

    single_valid_pulse: assert property (@(posedge baud_clk) disable iff (reset)
        rx_valid |=> !rx_valid)
        else $error("rx_valid held high for more than one cycle");

    // Every busy period is exactly ten cycles long
    busy_length: assert property (@(posedge baud_clk) disable iff (reset)
        $fell(tx_busy) |-> (busy_run == BUSY_CYCLES))
        else $error("tx_busy period length differs from ten cycles");

    busy_bounded: assert property (@(posedge baud_clk) disable iff (reset)
        busy_run <= BUSY_CYCLES)
        else $error("tx_busy stuck high past the end of a frame");

endmodule

bind uart_link uart_link_assertions u_assertions
(
    .baud_clk (baud_clk),
    .reset    (reset),
    .tx       (tx),
    .tx_busy  (tx_busy),
    .rx_valid (rx_valid)
);

// ==== testbench/uart_link_tb.sv ====
// Loopback testbench for uart_link, drives frames with error injection and checks each result
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_link_tb
    import uart_pkg::*;
();

    localparam bit PARITY_ODD = 1'b0;           // Even parity under test
    localparam int TIMEOUT_NS = 100 * 16 * 8;   // 100 frames of 16 cycles at 8 ns

    logic            baud_clk;
    logic            reset;
    uart_byte_t      tx_data;
    logic            start_tx;
    logic            tx;
    logic            tx_busy;
    logic            rx;
    logic            rx_valid;
    uart_rx_result_t rx_result;
    logic            inject;                    // Flips the looped-back line
    uart_rx_result_t expected_q[$];             // Results still to arrive, oldest first
    uart_rx_result_t want;
    integer          seed;
    logic [31:0]     rnd;
    int              pass_count;
    int              fail_count;
    int              errors_at_start;           // fail_count when the current test began

    tb_clock_gen u_clock_gen
    (
        .baud_clk (baud_clk),
        .reset    (reset)
    );

    assign rx = tx ^ inject;                    // Loopback with corruption

    uart_link
    #(
        .PARITY_ODD (PARITY_ODD)
    )
    uut
    (
        .baud_clk  (baud_clk),
        .reset     (reset),
        .tx_data   (tx_data),
        .start_tx  (start_tx),
        .tx        (tx),
        .tx_busy   (tx_busy),
        .rx        (rx),
        .rx_valid  (rx_valid),
        .rx_result (rx_result)
    );

    // Expected receive outcome, by the parity rule and the stop-bit rule
    function automatic uart_rx_result_t expected_result(input uart_byte_t value,
                                                        input bit flip_parity,
                                                        input bit force_stop);
        uart_rx_result_t result;
        logic            line_parity;
        logic            line_stop;
        line_parity = ((^value) ^ PARITY_ODD) ^ flip_parity;   // Parity as seen on the line
        line_stop   = `UART_IDLE_LEVEL ^ force_stop;
        result.data         = value;
        result.parity_error = (line_parity != ((^value) ^ PARITY_ODD));
        result.frame_error  = (line_stop != `UART_IDLE_LEVEL);
        return result;
    endfunction

    // Called just after a rising edge, returns at the edge that puts out the stop bit
    task automatic send_frame(input uart_byte_t value, input bit flip_parity,
                              input bit force_stop, input bit poke_busy);
        int k;
        expected_q.push_back(expected_result(value, flip_parity, force_stop));
        tx_data  <= value;
        start_tx <= 1'b1;
        @(posedge baud_clk);                    // Accepted, start bit on tx
        start_tx <= 1'b0;
        inject   <= 1'b0;                       // Ends stop injection of previous frame
        for (k = 1; k <= 10; k++)
        begin
            @(posedge baud_clk);                // Edge k drives frame bit k
            if (poke_busy && k == 3)
            begin
                tx_data  <= ~value;             // Must be ignored while busy
                start_tx <= 1'b1;
            end
            if (poke_busy && k == 4)
            begin
                start_tx <= 1'b0;
            end
            if (k == 9)
            begin
                inject <= flip_parity;          // Covers the parity bit cycle
            end
            if (k == 10)
            begin
                inject <= force_stop;           // Covers the stop bit cycle
            end
        end
    endtask

    task automatic wait_drain();
        @(posedge baud_clk);
        inject <= 1'b0;
        while (expected_q.size() != 0)
        begin
            @(posedge baud_clk);
        end
        repeat (`UART_FRAME_BITS + 4) @(posedge baud_clk);   // Window for a stray result
    endtask

    task automatic report_test(input string name);
        $display("%-18s finished, %0d errors", name, fail_count - errors_at_start);
        errors_at_start = fail_count;
    endtask

    // Compare each result against the oldest outstanding expectation
    always @(negedge baud_clk)
    begin
        if (!reset && rx_valid)
        begin
            if (expected_q.size() == 0)
            begin
                $display("Unexpected result %02h at %0t with no frame outstanding",
                         rx_result.data, $time);
                fail_count++;
            end
            else
            begin
                want = expected_q.pop_front();
                if (rx_result.data !== want.data)
                begin
                    $display("ERROR at %0t: data %02h, expected %02h",
                             $time, rx_result.data, want.data);
                    fail_count++;
                end
                else
                begin
                    pass_count++;
                end
                if (rx_result.parity_error !== want.parity_error)
                begin
                    $display("ERROR at %0t: parity_error %b, expected %b",
                             $time, rx_result.parity_error, want.parity_error);
                    fail_count++;
                end
                else
                begin
                    pass_count++;
                end
                if (rx_result.frame_error !== want.frame_error)
                begin
                    $display("ERROR at %0t: frame_error %b, expected %b",
                             $time, rx_result.frame_error, want.frame_error);
                    fail_count++;
                end
                else
                begin
                    pass_count++;
                end
            end
        end
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, %0d results never arrived", TIMEOUT_NS,
                 expected_q.size());
        $display("Test failed");
        $finish;
    end

    initial
    begin
        seed            = 32'h5916_718a;
        pass_count      = 0;
        fail_count      = 0;
        errors_at_start = 0;
        tx_data         = '0;
        start_tx        = 1'b0;
        inject          = 1'b0;
        wait (reset == 1'b0);
        @(negedge baud_clk);
        if (tx !== 1'b1 || tx_busy !== 1'b0 || rx_valid !== 1'b0)
        begin
            $display("ERROR at %0t: after reset tx %b busy %b valid %b", $time,
                     tx, tx_busy, rx_valid);
            fail_count++;
        end
        else
        begin
            pass_count++;
        end
        report_test("reset state");
        @(posedge baud_clk);
        send_frame(8'h00, 1'b0, 1'b0, 1'b0);    // Back to back from here
        send_frame(8'hFF, 1'b0, 1'b0, 1'b0);
        send_frame(8'hA5, 1'b0, 1'b0, 1'b0);
        repeat (40)
        begin
            rnd = $random(seed);
            send_frame(rnd[7:0], 1'b0, 1'b0, 1'b0);
        end
        wait_drain();
        report_test("clean loopback");
        send_frame(8'h3C, 1'b0, 1'b0, 1'b1);    // Second strobe lands mid frame
        wait_drain();
        report_test("busy ignores start");
        send_frame(8'h5A, 1'b1, 1'b0, 1'b0);
        send_frame(8'h01, 1'b1, 1'b0, 1'b0);
        wait_drain();
        report_test("parity error");
        send_frame(8'h81, 1'b0, 1'b1, 1'b0);
        send_frame(8'h7E, 1'b0, 1'b0, 1'b0);    // Must still arrive clean
        wait_drain();
        report_test("framing error");
        $display("Checks: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0)
        begin
            $display("Test passed");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== uart_link.f ====
+incdir+hdl
hdl/uart_pkg.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_link.sv
testbench/tb_clock_gen.sv
testbench/uart_link_assertions.sv
testbench/uart_link_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = uart_link_tb
FILELIST  = uart_link.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_TEXT = Test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
